/* source/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    // major opcodes accepted by the decoder
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    // funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7, only bit 30 differs between add and sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // one instruction word, seen as r-type or as i-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            // imm12 covers the funct7 and rs2 slots of the r view
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire

/* source/tomasula_pkg.sv */
`default_nettype none

package tomasula_pkg;

    // alu operation carried in each control word
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // control word fields, travelling as separate ports
    //   cw_op       3 bits
    //   cw_rd       5 bits
    //   cw_rs1      5 bits
    //   cw_rs2      5 bits
    //   cw_use_imm  1 bit
    //   cw_imm     32 bits, already sign extended
    // packed in that order, msb first, inside the queue
    localparam int CW_WIDTH = 51;

    // issue queue geometry
    localparam int IQ_DEPTH = 4;
    // pointer width, log2 of the depth
    localparam int IQ_PTR_W = 2;

endpackage

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import tomasula_pkg::*; (
    input  alu_op_e     op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] result_o
);

    // plain 32-bit wraparound, no overflow flag
    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            // unused encodings
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    // write port
    input  logic        we_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] wdata_i,
    // read ports
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [32];

    // x0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // asynchronous reads
    // a write lands on the edge, next cycle sees the new value
    assign rdata1_o = regs[rs1_i];
    assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

/* source/fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode import rv32i_pkg::*, tomasula_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    // instruction memory side
    output logic        instr_read_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_mem_resp_i,
    input  logic [31:0] instr_data_i,
    // issue queue side
    input  logic        full_i,
    output logic        push_o,
    output alu_op_e     cw_op_o,
    output logic [4:0]  cw_rd_o,
    output logic [4:0]  cw_rs1_o,
    output logic [4:0]  cw_rs2_o,
    output logic        cw_use_imm_o,
    output logic [31:0] cw_imm_o
);

    logic [31:0] pc_q;
    logic        read_q;
    logic        hold_q;
    logic        hold_d;
    logic        fetch_done;

    // decoder outputs
    instr_u      word;
    logic        dec_legal;
    alu_op_e     dec_op;
    logic [4:0]  dec_rs2;
    logic        dec_use_imm;
    logic [31:0] dec_imm;

    assign word         = instr_data_i;
    assign fetch_done   = read_q && instr_mem_resp_i;
    assign push_o       = hold_q && !full_i;
    assign instr_read_o = read_q;
    assign instr_addr_o = pc_q;

    always_comb begin
        dec_legal   = 1'b0;
        dec_op      = ALU_ADD;
        dec_rs2     = word.r.rs2;
        dec_use_imm = 1'b0;
        dec_imm     = '0;
        if (word.r.opcode == OP_REG) begin
            // register form checks funct7 against funct3
            if (word.r.funct7 == F7_BASE) begin
                dec_legal = 1'b1;
                case (word.r.funct3)
                    F3_ADD:  dec_op = ALU_ADD;
                    F3_XOR:  dec_op = ALU_XOR;
                    F3_OR:   dec_op = ALU_OR;
                    F3_AND:  dec_op = ALU_AND;
                    default: dec_legal = 1'b0;
                endcase
            end else if (word.r.funct7 == F7_SUB && word.r.funct3 == F3_ADD) begin
                dec_legal = 1'b1;
                dec_op    = ALU_SUB;
            end
        end else if (word.i.opcode == OP_IMM) begin
            // immediate form reads no second register
            dec_legal   = 1'b1;
            dec_rs2     = 5'd0;
            dec_use_imm = 1'b1;
            dec_imm     = {{20{word.i.imm12[11]}}, word.i.imm12};
            case (word.i.funct3)
                F3_ADD:  dec_op = ALU_ADD;
                F3_XOR:  dec_op = ALU_XOR;
                F3_OR:   dec_op = ALU_OR;
                F3_AND:  dec_op = ALU_AND;
                default: dec_legal = 1'b0;
            endcase
        end
    end

    // holding register fills on a legal response and drains on push
    always_comb begin
        hold_d = hold_q;
        if (fetch_done && dec_legal) begin
            hold_d = 1'b1;
        end else if (push_o) begin
            hold_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q   <= '0;
            read_q <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            hold_q <= hold_d;
            // keep requesting while there is room to park a word
            read_q <= !hold_d;
            // pc moves on after every response including illegal words
            if (fetch_done) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // control word payload loads with each legal word
    always_ff @(posedge clk_i) begin
        if (fetch_done && dec_legal) begin
            cw_op_o      <= dec_op;
            cw_rd_o      <= word.r.rd;
            cw_rs1_o     <= word.r.rs1;
            cw_rs2_o     <= dec_rs2;
            cw_use_imm_o <= dec_use_imm;
            cw_imm_o     <= dec_imm;
        end
    end

    // address holds until the memory responds
    addr_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_read_o && !instr_mem_resp_i |=> $stable(instr_addr_o));

endmodule

`default_nettype wire

/* source/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue import tomasula_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    // producer side
    input  logic        push_i,
    input  alu_op_e     cw_op_i,
    input  logic [4:0]  cw_rd_i,
    input  logic [4:0]  cw_rs1_i,
    input  logic [4:0]  cw_rs2_i,
    input  logic        cw_use_imm_i,
    input  logic [31:0] cw_imm_i,
    // consumer side
    input  logic        pop_i,
    output logic        full_o,
    output logic        empty_o,
    output alu_op_e     cw_op_o,
    output logic [4:0]  cw_rd_o,
    output logic [4:0]  cw_rs1_o,
    output logic [4:0]  cw_rs2_o,
    output logic        cw_use_imm_o,
    output logic [31:0] cw_imm_o
);

    logic [CW_WIDTH-1:0] mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] wr_ptr_q;
    logic [IQ_PTR_W-1:0] rd_ptr_q;
    logic [IQ_PTR_W:0]   count_q;
    logic [CW_WIDTH-1:0] push_word;
    logic [CW_WIDTH-1:0] head_word;
    logic [2:0]          head_op;
    logic                do_push;
    logic                do_pop;

    assign full_o  = count_q == (IQ_PTR_W + 1)'(IQ_DEPTH);
    assign empty_o = count_q == '0;
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign push_word = {cw_op_i, cw_rd_i, cw_rs1_i, cw_rs2_i, cw_use_imm_i, cw_imm_i};

    // head entry unpacked back into fields
    assign head_word = mem[rd_ptr_q];
    assign {head_op, cw_rd_o, cw_rs1_o, cw_rs2_o, cw_use_imm_o, cw_imm_o} = head_word;
    assign cw_op_o = alu_op_e'(head_op);

    // entry storage written at the tail
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_word;
        end
    end

    // pointers wrap at the power of two depth
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // producer respects full and consumer respects empty
    no_push_full_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> !full_o);
    no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import tomasula_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    // queue head
    input  logic        empty_i,
    input  alu_op_e     cw_op_i,
    input  logic [4:0]  cw_rd_i,
    input  logic [4:0]  cw_rs1_i,
    input  logic [4:0]  cw_rs2_i,
    input  logic        cw_use_imm_i,
    input  logic [31:0] cw_imm_i,
    // stand in for a full rob
    input  logic        rob_full_i,
    output logic        pop_o,
    // retirement report
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] operand_b;
    logic [31:0] result;

    // issue whenever something waits and the rob has room
    assign pop_o = !empty_i && !rob_full_i;

    // immediate replaces rs2 for i-type
    assign operand_b = cw_use_imm_i ? cw_imm_i : rs2_data;

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (pop_o),
        .rd_i     (cw_rd_i),
        .wdata_i  (result),
        .rs1_i    (cw_rs1_i),
        .rs2_i    (cw_rs2_i),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    alu u_alu (
        .op_i     (cw_op_i),
        .a_i      (rs1_data),
        .b_i      (operand_b),
        .result_o (result)
    );

    // report on the same edge as the register write
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            wb_rd_o   <= cw_rd_i;
            wb_data_o <= result;
        end
    end

    // a full rob in one cycle means no retirement in the next
    stall_holds_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rob_full_i |=> !wb_valid_o);

endmodule

`default_nettype wire

/* source/core_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module core_frontend import tomasula_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    // instruction memory
    output logic        instr_read_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_mem_resp_i,
    input  logic [31:0] instr_data_i,
    // backpressure
    input  logic        rob_full_i,
    // retirement
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    // fetch to queue
    logic        push;
    logic        full;
    alu_op_e     in_op;
    logic [4:0]  in_rd;
    logic [4:0]  in_rs1;
    logic [4:0]  in_rs2;
    logic        in_use_imm;
    logic [31:0] in_imm;

    // queue to execute
    logic        pop;
    logic        empty;
    alu_op_e     head_op;
    logic [4:0]  head_rd;
    logic [4:0]  head_rs1;
    logic [4:0]  head_rs2;
    logic        head_use_imm;
    logic [31:0] head_imm;

    fetch_decode u_fetch_decode (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .instr_read_o     (instr_read_o),
        .instr_addr_o     (instr_addr_o),
        .instr_mem_resp_i (instr_mem_resp_i),
        .instr_data_i     (instr_data_i),
        .full_i           (full),
        .push_o           (push),
        .cw_op_o          (in_op),
        .cw_rd_o          (in_rd),
        .cw_rs1_o         (in_rs1),
        .cw_rs2_o         (in_rs2),
        .cw_use_imm_o     (in_use_imm),
        .cw_imm_o         (in_imm)
    );

    issue_queue u_issue_queue (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push),
        .cw_op_i      (in_op),
        .cw_rd_i      (in_rd),
        .cw_rs1_i     (in_rs1),
        .cw_rs2_i     (in_rs2),
        .cw_use_imm_i (in_use_imm),
        .cw_imm_i     (in_imm),
        .pop_i        (pop),
        .full_o       (full),
        .empty_o      (empty),
        .cw_op_o      (head_op),
        .cw_rd_o      (head_rd),
        .cw_rs1_o     (head_rs1),
        .cw_rs2_o     (head_rs2),
        .cw_use_imm_o (head_use_imm),
        .cw_imm_o     (head_imm)
    );

    execute_unit u_execute_unit (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .empty_i      (empty),
        .cw_op_i      (head_op),
        .cw_rd_i      (head_rd),
        .cw_rs1_i     (head_rs1),
        .cw_rs2_i     (head_rs2),
        .cw_use_imm_i (head_use_imm),
        .cw_imm_i     (head_imm),
        .rob_full_i   (rob_full_i),
        .pop_o        (pop),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

`default_nettype wire

/* tests/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// r-type encoding, opcode 0110011
function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// i-type encoding, opcode 0010011
function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

// one program word from one random draw
function automatic logic [31:0] random_instr(input logic [31:0] r);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    // low registers only, so dependencies are frequent
    rd  = {2'b00, r[10:8]};
    rs1 = {2'b00, r[13:11]};
    rs2 = {2'b00, r[16:14]};
    imm = r[28:17];
    // about one word in ten is illegal
    if (r[7:0] < 8'd26) begin
        case (r[30:29])
            // branch opcode
            2'd0:    return {r[31:7], 7'b1100011};
            // mul, funct7 of the m extension
            2'd1:    return make_r(7'b0000001, rs2, rs1, 3'b000, rd);
            // slli
            2'd2:    return make_i(imm, rs1, 3'b001, rd);
            // sub funct7 with and funct3
            default: return make_r(7'b0100000, rs2, rs1, 3'b111, rd);
        endcase
    end
    case (r[31:30])
        2'd0:    f3 = 3'b000;
        2'd1:    f3 = 3'b100;
        2'd2:    f3 = 3'b110;
        default: f3 = 3'b111;
    endcase
    if (r[29]) begin
        // sub only exists next to funct3 000
        if (f3 == 3'b000 && r[28]) begin
            return make_r(7'b0100000, rs2, rs1, f3, rd);
        end
        return make_r(7'b0000000, rs2, rs1, f3, rd);
    end
    return make_i(imm, rs1, f3, rd);
endfunction

// addi x0 past the program, immediate folded from the address
function automatic logic [31:0] filler_word(input logic [31:0] addr);
    logic [11:0] imm;
    imm = addr[11:0] ^ addr[23:12] ^ {4'b0000, addr[31:24]};
    return make_i(imm, 5'd0, 3'b000, 5'd0);
endfunction

function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:2] < 30'(PROG_WORDS)) begin
        return program_mem[addr[9:2]];
    end
    return filler_word(addr);
endfunction

task automatic fill_program();
    logic [31:0] s;
    s = SEED;
    for (int n = 0; n < PROG_WORDS; n++) begin
        s = xorshift32(s);
        program_mem[n] = random_instr(s);
    end
endtask

// walk the program in order, legal words only
task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        f3_ok;
    logic        ok;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    legal_total = 0;
    for (int n = 0; n < PROG_WORDS; n++) begin
        w     = program_mem[n];
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = regs[w[19:15]];
        f3_ok = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
        ok    = 1'b0;
        b     = '0;
        if (opc == 7'b0110011) begin
            b  = regs[w[24:20]];
            ok = f3_ok && (f7 == 7'b0000000 || (f7 == 7'b0100000 && f3 == 3'b000));
        end else if (opc == 7'b0010011) begin
            b  = {{20{w[31]}}, w[31:20]};
            ok = f3_ok;
        end
        case (f3)
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            // bit 30 set only on sub here
            default: res = (opc == 7'b0110011 && w[30]) ? a - b : a + b;
        endcase
        if (ok) begin
            exp_rd_q.push_back(w[11:7]);
            exp_data_q.push_back(res);
            legal_total++;
            if (w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
        end
    end
endtask

`endif

/* tests/tb_core_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_frontend;

    localparam int          PROG_WORDS     = 200;
    localparam logic [31:0] SEED           = 32'd9308;
    localparam int          RUN_TIMEOUT    = 20000;
    localparam int          STALL_CYCLES   = 60;
    localparam int          RESUME_LIMIT   = 20;
    localparam int          FILLER_RETIRES = 4;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        instr_mem_resp = 1'b0;
    logic [31:0] instr_data = '0;
    logic        rob_full = 1'b0;
    logic        instr_read;
    logic [31:0] instr_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // program image and expected retirements
    logic [31:0] program_mem [PROG_WORDS];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          legal_total = 0;
    int          retired = 0;
    int          filler_seen = 0;

    // memory model and rob burst state
    logic [31:0] drive_rng = SEED;
    logic        busy = 1'b0;
    int          delay_left = 0;
    logic [31:0] next_addr = '0;
    int          burst_left = 0;
    int          long_left = 0;
    logic        long_done = 1'b0;
    int          resume_wait = 0;

    `include "tb_ref_model.svh"

    core_frontend u_dut (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .instr_read_o     (instr_read),
        .instr_addr_o     (instr_addr),
        .instr_mem_resp_i (instr_mem_resp),
        .instr_data_i     (instr_data),
        .rob_full_i       (rob_full),
        .wb_valid_o       (wb_valid),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s expected %08h actual %08h", name, expected, actual);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic halt_with_message(input string what);
        $display("Error: %s", what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    // idle fetch port and report during reset and on release
    reset_quiet_a: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> (!instr_read && !wb_valid && instr_addr == 32'd0))
        else halt_with_message("outputs not idle during or right after reset");

    // pending request keeps its address
    addr_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        instr_read && !instr_mem_resp |=> instr_read && $stable(instr_addr))
        else halt_with_message("request dropped or address moved before the response");

    // every response moves the pc by one word
    addr_step_a: assert property (@(posedge clk) disable iff (!arst_n)
        instr_read && instr_mem_resp |=> instr_addr == $past(instr_addr) + 32'd4)
        else halt_with_message("fetch address did not advance by 4 after a response");

    // no retirement right after a full rob
    stall_a: assert property (@(posedge clk) disable iff (!arst_n)
        rob_full |=> !wb_valid)
        else halt_with_message("retirement in the cycle after rob_full was high");

    task automatic check_retirement();
        logic [31:0] fill_addr;
        logic [31:0] fill_w;
        // retirement must come back soon after the long stall
        if (resume_wait > 0) begin
            if (wb_valid) begin
                resume_wait = 0;
            end else if (resume_wait >= RESUME_LIMIT) begin
                halt_with_message("no retirement after the long stall was released");
            end else begin
                resume_wait++;
            end
        end
        if (wb_valid) begin
            if (exp_rd_q.size() > 0) begin
                assert (wb_rd == exp_rd_q[0])
                    else report_mismatch("writeback_rd", {27'd0, exp_rd_q[0]}, {27'd0, wb_rd});
                assert (wb_data == exp_data_q[0])
                    else report_mismatch("writeback_data", exp_data_q[0], wb_data);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                retired++;
            end else begin
                // past the program only addi x0 fillers retire
                fill_addr = 32'((PROG_WORDS + filler_seen) * 4);
                fill_w    = filler_word(fill_addr);
                assert (wb_rd == 5'd0)
                    else report_mismatch("filler_rd", 32'd0, {27'd0, wb_rd});
                assert (wb_data == {{20{fill_w[31]}}, fill_w[31:20]})
                    else report_mismatch("filler_data", {{20{fill_w[31]}}, fill_w[31:20]},
                                         wb_data);
                filler_seen++;
            end
        end
    endtask

    task automatic serve_memory();
        // a response shown last cycle ended its request at the edge
        if (instr_mem_resp) begin
            instr_mem_resp = 1'b0;
            busy           = 1'b0;
        end
        if (instr_read && !busy) begin
            assert (instr_addr == next_addr)
                else report_mismatch("fetch_addr", next_addr, instr_addr);
            busy       = 1'b1;
            drive_rng  = xorshift32(drive_rng);
            delay_left = int'(drive_rng[1:0]);
        end
        if (busy) begin
            if (delay_left == 0) begin
                instr_mem_resp = 1'b1;
                instr_data     = fetch_word(instr_addr);
                next_addr      = instr_addr + 32'd4;
            end else begin
                delay_left--;
            end
        end
    endtask

    task automatic drive_rob();
        // one long stall halfway fills the queue and the holding register
        if (!long_done && retired >= legal_total / 2) begin
            long_done = 1'b1;
            long_left = STALL_CYCLES;
        end
        if (long_left > 0) begin
            rob_full = 1'b1;
            long_left--;
            if (long_left == 0) begin
                assert (!instr_read)
                    else halt_with_message("fetch still requesting with the queue full");
                resume_wait = 1;
            end
        end else if (burst_left > 0) begin
            rob_full = 1'b1;
            burst_left--;
        end else begin
            drive_rng  = xorshift32(drive_rng);
            // roughly one cycle in sixteen opens a short burst
            rob_full   = (drive_rng[3:0] == 4'd0);
            burst_left = rob_full ? int'(drive_rng[5:4]) : 0;
        end
    endtask

    // inputs change on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (arst_n) begin
            check_retirement();
            serve_memory();
            drive_rob();
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        fill_program();
        build_expected();
        repeat (8) @(negedge clk);
        arst_n <= 1'b1;
        // every legal word retires first, then the fillers behind the program
        while ((exp_rd_q.size() > 0 || filler_seen < FILLER_RETIRES)
               && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd_q.size() > 0 || filler_seen < FILLER_RETIRES) begin
            halt_with_message("timeout waiting for the program to retire");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* core_frontend.f */
source/rv32i_pkg.sv
source/tomasula_pkg.sv
source/alu.sv
source/regfile.sv
source/fetch_decode.sv
source/issue_queue.sv
source/execute_unit.sv
source/core_frontend.sv
+incdir+tests
tests/tb_core_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module tb_core_frontend \
    -f core_frontend.f \
    -o sim_core_frontend
out=$(./obj_dir/sim_core_frontend 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed"
